/* Bender.yml */
package:
  name: load_store_unit

export_include_dirs:
  - include

sources:
  - logic/lsu_pkg.sv
  - logic/lsu_addr_gen.sv
  - logic/lsu_bypass.sv
  - logic/lsu_addr_check.sv
  - logic/load_unit.sv
  - logic/store_unit.sv
  - logic/lsu_result_pipe.sv
  - logic/load_store_unit.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_load_store_unit.sv

/* dv/tb_clk_gen.sv */
// testbench clock and reset source, instantiated once by the testbench top
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int unsigned period_ns  = 10,
    parameter int unsigned rst_cycles = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2.0) clk_o = ~clk_o;
    end

    // reset held low for the first few edges
    initial begin
        rst_no = 1'b0;
        repeat (rst_cycles) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

/* dv/tb_load_store_unit.sv */
// testbench top of the load/store front end, memory model, random and directed stimulus, checks
`timescale 1ns/10ps
`include "lsu_consts.svh"

module tb_load_store_unit import lsu_pkg::*; ();

    localparam int unsigned   n_ids   = 1 << `LSU_TRANS_ID_BITS;
    localparam int unsigned   n_rand  = 40;
    localparam int unsigned   n_req   = 2 * n_rand + 6;
    localparam logic [63:0]   mem_key = 64'h5a5a_c3c3_0f0f_9696;
    // bit 39 set, upper bits not all equal
    localparam logic [63:0]   nc_base = 64'h0000_0080_0000_1000;

    logic                          clk_i, rst_ni, flush_i, en_ld_st_translation_i;
    logic                          lsu_valid_i, lsu_ready_o;
    logic [`LSU_XLEN-1:0]          operand_a_i, operand_b_i, imm_i;
    fu_t                           fu_i;
    lsu_op_t                       op_i;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i;
    logic                          ld_req_o, ld_rvalid_i, st_req_o, st_gnt_i;
    logic [`LSU_XLEN-1:0]          ld_addr_o, ld_rdata_i, st_addr_o, st_wdata_o;
    logic [7:0]                    ld_be_o, st_be_o;
    logic                          load_valid_o, store_valid_o;
    logic [`LSU_TRANS_ID_BITS-1:0] load_trans_id_o, store_trans_id_o;
    logic [`LSU_XLEN-1:0]          load_result_o, store_result_o;
    exception_t                    load_exception_o, store_exception_o;

    // scoreboard by trans_id
    logic                          exp_pending [n_ids];
    logic                          exp_is_load [n_ids];
    logic                          exp_exc     [n_ids];
    exc_cause_t                    exp_cause   [n_ids];
    logic [63:0]                   exp_tval    [n_ids];
    logic [63:0]                   exp_result  [n_ids];
    logic [`LSU_TRANS_ID_BITS-1:0] next_id;
    // expected memory traffic in issue order, {be, addr} and {be, addr, data}
    logic [71:0]                   ld_exp [$];
    logic [135:0]                  st_exp [$];
    // memory model state
    logic                          ld_busy, ld_slow;
    int                            ld_delay;
    logic [63:0]                   ld_word;
    // driven request raises an exception
    logic                          req_exc;
    // fault-free request waiting in the buffer, as seen from the ports
    logic                          held;

    tb_clk_gen #(.period_ns(10), .rst_cycles(5)) i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

    load_store_unit i_dut (.*);

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic int unsigned access_bytes(input lsu_op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            default:              return 8;
        endcase
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < n_ids; i++) begin
            n += exp_pending[i];
        end
        return n;
    endfunction

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic send_req(input lsu_op_t op, input logic [63:0] base, input logic [63:0] imm,
                            input logic [63:0] data, input logic flushed);
        logic [63:0]                   va;
        logic [63:0]                   keep;
        logic [63:0]                   word;
        logic [7:0]                    be;
        logic [`LSU_TRANS_ID_BITS-1:0] id;
        int unsigned                   nbytes;
        logic                          is_load;
        logic                          fault;
        logic                          mis;
        id      = next_id;
        next_id = next_id + 1'b1;
        is_load = (op <= OP_LD);
        nbytes  = access_bytes(op);
        va      = base + imm;
        be      = 8'(((1 << nbytes) - 1) << va[2:0]);
        mis     = (va % nbytes) != 0;
        // free buffer and a retired id
        do begin
            @(negedge clk_i);
        end while (!lsu_ready_o || exp_pending[id]);
        // canonical when the address is the sign extension of its low 39 bits
        fault   = en_ld_st_translation_i && (va != {{25{va[38]}}, va[38:0]});
        if (!flushed) begin
            exp_pending[id] = 1'b1;
            exp_is_load[id] = is_load;
            exp_exc[id]     = fault || mis;
            exp_tval[id]    = va;
            if (fault) begin
                exp_cause[id] = is_load ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
            end else begin
                exp_cause[id] = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            end
            // memory word of the aligned address, moved down to bit 0 and extended
            keep = (nbytes == 8) ? '1 : ((64'd1 << (8 * nbytes)) - 64'd1);
            word = (({va[63:3], 3'b000} ^ mem_key) >> (8 * va[2:0])) & keep;
            if ((op inside {OP_LB, OP_LH, OP_LW}) && word[8*nbytes-1]) begin
                word = word | ~keep;
            end
            exp_result[id] = is_load ? word : '0;
            if (!exp_exc[id] && is_load) begin
                ld_exp.push_back({be, va[63:3], 3'b000});
            end else if (!exp_exc[id]) begin
                st_exp.push_back({be, va[63:3], 3'b000, data << (8 * va[2:0])});
            end
        end
        @(posedge clk_i);
        lsu_valid_i <= 1'b1;
        req_exc     <= fault || mis;
        operand_a_i <= base;
        imm_i       <= imm;
        operand_b_i <= data;
        op_i        <= op;
        fu_i        <= is_load ? FU_LOAD : FU_STORE;
        trans_id_i  <= id;
        @(posedge clk_i);
        lsu_valid_i <= 1'b0;
    endtask

    task automatic random_request();
        lsu_op_t     op;
        logic [63:0] base;
        logic [2:0]  lane;
        op   = lsu_op_t'($urandom_range(10, 0));
        base = {32'h0, $urandom} & ~64'h7;
        // now and then off the canonical range
        if ($urandom_range(5, 0) == 0) begin
            base[45] = 1'b1;
        end
        lane = $urandom_range(7, 0);
        // mostly aligned, in a random lane
        if ($urandom_range(3, 0) != 0) begin
            lane = lane & ~3'(access_bytes(op) - 1);
        end
        send_req(op, base, int'(lane) - 16, {$urandom, $urandom}, 1'b0);
    endtask

    task automatic drain();
        while (outstanding() != 0) begin
            @(negedge clk_i);
        end
    endtask

    initial begin : stimulus
        int unsigned seed_ret;
        seed_ret               = $urandom(1);
        flush_i                = 1'b0;
        en_ld_st_translation_i = 1'b0;
        lsu_valid_i            = 1'b0;
        operand_a_i            = '0;
        operand_b_i            = '0;
        imm_i                  = '0;
        fu_i                   = FU_NONE;
        op_i                   = OP_LB;
        trans_id_i             = '0;
        ld_rvalid_i            = 1'b0;
        ld_rdata_i             = '0;
        st_gnt_i               = 1'b0;
        ld_busy                = 1'b0;
        ld_slow                = 1'b0;
        ld_delay               = 0;
        req_exc                = 1'b0;
        held                   = 1'b0;
        next_id                = '0;
        for (int i = 0; i < n_ids; i++) begin
            exp_pending[i] = 1'b0;
        end
        wait (rst_ni === 1'b1);
        // translation on, faults expected
        @(posedge clk_i);
        en_ld_st_translation_i <= 1'b1;
        repeat (n_rand) random_request();
        send_req(OP_LW, nc_base, 64'd4, 64'h1111_2222_3333_4444, 1'b0);
        send_req(OP_SD, nc_base, 64'd8, 64'h5555_6666_7777_8888, 1'b0);
        drain();
        // translation off, same addresses complete
        @(posedge clk_i);
        en_ld_st_translation_i <= 1'b0;
        repeat (n_rand) random_request();
        send_req(OP_LW, nc_base, 64'd4, 64'h1111_2222_3333_4444, 1'b0);
        send_req(OP_SD, nc_base, 64'd8, 64'h5555_6666_7777_8888, 1'b0);
        drain();
        // slow load keeps the unit busy, second load waits in the buffer
        ld_slow = 1'b1;
        send_req(OP_LD, 64'h2000, 64'd0, '0, 1'b0);
        send_req(OP_LBU, 64'h3000, 64'd5, '0, 1'b1);
        @(negedge clk_i);
        assert (!lsu_ready_o) else fail_run("flush test load was not held in the buffer");
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        drain();
        ld_slow = 1'b0;
        // room for a leaked request to show up
        repeat (20) @(posedge clk_i);
        if (outstanding() == 0 && ld_exp.size() == 0 && st_exp.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("requests left without result or memory access at the end of the run");
        end
    end

    initial begin : watchdog
        repeat (200 * n_req) @(posedge clk_i);
        fail_run("timeout, the requests did not complete in time");
    end

    // ------------------------------
    // memory model
    // ------------------------------
    always @(posedge clk_i) begin
        ld_rvalid_i <= 1'b0;
        // grant held off two cycles in three on average
        st_gnt_i    <= ($urandom_range(2, 0) == 0);
        if (rst_ni && ld_req_o) begin
            assert (ld_exp.size() != 0) else fail_run("load request with none expected");
            assert ({ld_be_o, ld_addr_o} == ld_exp[0]) else
                fail_run($sformatf("ERR {ld_be_o, ld_addr_o} got %h exp %h",
                                   {ld_be_o, ld_addr_o}, ld_exp[0]));
            void'(ld_exp.pop_front());
            ld_word  = ld_addr_o ^ mem_key;
            ld_delay = ld_slow ? 10 : $urandom_range(3, 0);
            ld_busy  = 1'b1;
        end
        // response at least one cycle after the request
        if (ld_busy && ld_delay == 0) begin
            ld_rvalid_i <= 1'b1;
            ld_rdata_i  <= ld_word;
            ld_busy      = 1'b0;
        end else if (ld_busy) begin
            ld_delay = ld_delay - 1;
        end
        if (rst_ni && st_req_o && st_gnt_i) begin
            assert (st_exp.size() != 0) else fail_run("store granted with none expected");
            assert ({st_be_o, st_addr_o, st_wdata_o} == st_exp[0]) else
                fail_run($sformatf("ERR {st_be_o, st_addr_o, st_wdata_o} got %h exp %h",
                                   {st_be_o, st_addr_o, st_wdata_o}, st_exp[0]));
            void'(st_exp.pop_front());
        end
    end

    // ------------------------------
    // result checks
    // ------------------------------
    task automatic check_result(input logic is_load, input logic [`LSU_TRANS_ID_BITS-1:0] id,
                                input logic [63:0] res, input exception_t ex);
        string kind;
        kind = is_load ? "load" : "store";
        assert (exp_pending[id] && exp_is_load[id] == is_load) else
            fail_run($sformatf("unexpected %s result for trans_id %0d", kind, id));
        assert (ex.valid == exp_exc[id]) else
            fail_run($sformatf("ERR %s_exception_o.valid got %h exp %h (trans_id %h)",
                               kind, ex.valid, exp_exc[id], id));
        if (exp_exc[id]) begin
            assert (ex.cause == exp_cause[id]) else
                fail_run($sformatf("ERR %s_exception_o.cause got %h exp %h",
                                   kind, ex.cause, exp_cause[id]));
            assert (ex.tval == exp_tval[id]) else
                fail_run($sformatf("ERR %s_exception_o.tval got %h exp %h",
                                   kind, ex.tval, exp_tval[id]));
        end else begin
            assert (res == exp_result[id]) else
                fail_run($sformatf("ERR %s_result_o got %h exp %h (trans_id %h)",
                                   kind, res, exp_result[id], id));
        end
        // each id completes once
        exp_pending[id] = 1'b0;
    endtask

    always @(posedge clk_i) begin
        if (rst_ni) begin
            assert (!(held && lsu_ready_o)) else
                fail_run("lsu_ready_o high while the request buffer holds an item");
            if (load_valid_o) begin
                check_result(1'b1, load_trans_id_o, load_result_o, load_exception_o);
            end
            if (store_valid_o) begin
                check_result(1'b0, store_trans_id_o, store_result_o, store_exception_o);
            end
        end
        // an accepted request stays buffered until its memory access or a flush
        if (!rst_ni || flush_i || ld_req_o || (st_req_o && st_gnt_i)) begin
            held = 1'b0;
        end else if (lsu_valid_i && !req_exc) begin
            held = 1'b1;
        end
    end

endmodule

/* include/lsu_consts.svh */
// width and depth constants of the load/store front end, included by the package and the RTL
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ------------------------------
// datapath widths
// ------------------------------
// data and address width
`define LSU_XLEN 64
// scoreboard transaction id
`define LSU_TRANS_ID_BITS 3
// sv39, bits above this must all match
`define LSU_VA_BITS 39

// ------------------------------
// result output stages
// ------------------------------
`define LSU_LOAD_PIPE_REGS 1
`define LSU_STORE_PIPE_REGS 1

`endif

/* logic/load_store_unit.sv */
// top level of the load/store front end, wiring address path, buffer, units and result stages
`timescale 1ns/10ps
`include "lsu_consts.svh"

module load_store_unit import lsu_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  logic                          en_ld_st_translation_i,
    // request side
    input  logic                          lsu_valid_i,
    input  logic [`LSU_XLEN-1:0]          operand_a_i,
    input  logic [`LSU_XLEN-1:0]          operand_b_i,
    input  logic [`LSU_XLEN-1:0]          imm_i,
    input  fu_t                           fu_i,
    input  lsu_op_t                       op_i,
    input  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i,
    output logic                          lsu_ready_o,
    // load memory port
    output logic                          ld_req_o,
    output logic [`LSU_XLEN-1:0]          ld_addr_o,
    output logic [7:0]                    ld_be_o,
    input  logic                          ld_rvalid_i,
    input  logic [`LSU_XLEN-1:0]          ld_rdata_i,
    // store memory port
    output logic                          st_req_o,
    output logic [`LSU_XLEN-1:0]          st_addr_o,
    output logic [7:0]                    st_be_o,
    output logic [`LSU_XLEN-1:0]          st_wdata_o,
    input  logic                          st_gnt_i,
    // results
    output logic                          load_valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0] load_trans_id_o,
    output logic [`LSU_XLEN-1:0]          load_result_o,
    output exception_t                    load_exception_o,
    output logic                          store_valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0] store_trans_id_o,
    output logic [`LSU_XLEN-1:0]          store_result_o,
    output exception_t                    store_exception_o
);

    localparam int unsigned res_width = 1 + `LSU_TRANS_ID_BITS + `LSU_XLEN + $bits(exception_t);

    lsu_ctrl_t                     req;
    lsu_ctrl_t                     head;
    exception_t                    head_ex;
    logic                          pop_ld, pop_st;
    logic                          ld_valid_in, st_valid_in;
    logic                          ld_valid, st_valid;
    logic [`LSU_TRANS_ID_BITS-1:0] ld_id, st_id;
    logic [`LSU_XLEN-1:0]          ld_result, st_result;
    exception_t                    ld_ex, st_ex;

    lsu_addr_gen i_addr_gen (
        .operand_a_i, .imm_i, .operand_b_i, .fu_i, .op_i, .trans_id_i, .lsu_valid_i,
        .req_o (req)
    );

    lsu_bypass i_bypass (
        .clk_i, .rst_ni, .flush_i,
        .req_i    (req),
        .pop_ld_i (pop_ld),
        .pop_st_i (pop_st),
        .ctrl_o   (head),
        .ready_o  (lsu_ready_o)
    );

    lsu_addr_check i_addr_check (
        .ctrl_i (head), .en_ld_st_translation_i,
        .ex_o   (head_ex)
    );

    // ------------------------------
    // dispatch by unit tag
    // ------------------------------
    assign ld_valid_in = head.valid && (head.fu == FU_LOAD);
    assign st_valid_in = head.valid && (head.fu == FU_STORE);

    load_unit i_load_unit (
        .clk_i, .rst_ni, .ld_rvalid_i, .ld_rdata_i, .ld_req_o, .ld_addr_o, .ld_be_o,
        .valid_i (ld_valid_in), .ctrl_i (head), .ex_i (head_ex), .pop_ld_o (pop_ld),
        .valid_o (ld_valid), .trans_id_o (ld_id), .result_o (ld_result), .ex_o (ld_ex)
    );

    store_unit i_store_unit (
        .clk_i, .rst_ni, .st_gnt_i, .st_req_o, .st_addr_o, .st_be_o, .st_wdata_o,
        .valid_i (st_valid_in), .ctrl_i (head), .ex_i (head_ex), .pop_st_o (pop_st),
        .valid_o (st_valid), .trans_id_o (st_id), .result_o (st_result), .ex_o (st_ex)
    );

    // ------------------------------
    // output stages
    // ------------------------------
    lsu_result_pipe #(.width(res_width), .depth(`LSU_LOAD_PIPE_REGS)) i_ld_pipe (
        .clk_i, .rst_ni,
        .d_i ({ld_valid, ld_id, ld_result, ld_ex}),
        .d_o ({load_valid_o, load_trans_id_o, load_result_o, load_exception_o})
    );

    lsu_result_pipe #(.width(res_width), .depth(`LSU_STORE_PIPE_REGS)) i_st_pipe (
        .clk_i, .rst_ni,
        .d_i ({st_valid, st_id, st_result, st_ex}),
        .d_o ({store_valid_o, store_trans_id_o, store_result_o, store_exception_o})
    );

endmodule

/* logic/load_unit.sv */
// load unit, one outstanding load, aligns and extends the returned double word
`timescale 1ns/10ps
`include "lsu_consts.svh"

module load_unit import lsu_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          valid_i,
    input  lsu_ctrl_t                     ctrl_i,
    input  exception_t                    ex_i,
    input  logic                          ld_rvalid_i,
    input  logic [`LSU_XLEN-1:0]          ld_rdata_i,
    output logic                          pop_ld_o,
    output logic                          ld_req_o,
    output logic [`LSU_XLEN-1:0]          ld_addr_o,
    output logic [7:0]                    ld_be_o,
    output logic                          valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0] trans_id_o,
    output logic [`LSU_XLEN-1:0]          result_o,
    output exception_t                    ex_o
);

    load_state_t                   state_d, state_q;
    lsu_op_t                       op_q;
    logic [2:0]                    off_q;
    logic [`LSU_TRANS_ID_BITS-1:0] id_q;
    logic [`LSU_XLEN-1:0]          shifted;
    logic [`LSU_XLEN-1:0]          ext;
    logic                          take;

    // head taken only while idle
    assign take      = valid_i && (state_q == LD_IDLE);
    assign pop_ld_o  = take;
    // faulting loads never reach memory
    assign ld_req_o  = take && !ex_i.valid;
    assign ld_addr_o = {ctrl_i.vaddr[`LSU_XLEN-1:3], 3'b000};
    assign ld_be_o   = ctrl_i.be;

    // ------------------------------
    // data alignment
    // ------------------------------
    assign shifted = ld_rdata_i >> {off_q, 3'b000};

    always_comb begin
        unique case (op_q)
            OP_LB:   ext = {{56{shifted[7]}}, shifted[7:0]};
            OP_LBU:  ext = {56'b0, shifted[7:0]};
            OP_LH:   ext = {{48{shifted[15]}}, shifted[15:0]};
            OP_LHU:  ext = {48'b0, shifted[15:0]};
            OP_LW:   ext = {{32{shifted[31]}}, shifted[31:0]};
            OP_LWU:  ext = {32'b0, shifted[31:0]};
            default: ext = shifted;
        endcase
    end

    always_comb begin
        state_d = state_q;
        if (ld_req_o) begin
            state_d = LD_WAIT_RVALID;
        end else if ((state_q == LD_WAIT_RVALID) && ld_rvalid_i) begin
            state_d = LD_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= LD_IDLE;
            valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // result on response or straight away on a fault
            valid_o <= (take && ex_i.valid) || ((state_q == LD_WAIT_RVALID) && ld_rvalid_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (ld_req_o) begin
            op_q  <= ctrl_i.op;
            off_q <= ctrl_i.vaddr[2:0];
            id_q  <= ctrl_i.trans_id;
        end
        if (take && ex_i.valid) begin
            trans_id_o <= ctrl_i.trans_id;
            result_o   <= '0;
            ex_o       <= ex_i;
        end else begin
            trans_id_o <= id_q;
            result_o   <= ext;
            ex_o       <= '0;
        end
    end

    // memory answers only the outstanding load
    a_rvalid_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld_rvalid_i |-> (state_q == LD_WAIT_RVALID));

endmodule

/* logic/lsu_addr_check.sv */
// misalignment and sv39 canonical check of the head request, producing its exception
`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_addr_check import lsu_pkg::*; (
    input  lsu_ctrl_t  ctrl_i,
    input  logic       en_ld_st_translation_i,
    output exception_t ex_o
);

    logic                            misaligned;
    logic                            non_canonical;
    logic [`LSU_XLEN-`LSU_VA_BITS:0] upper;

    // bits from va_bits-1 upward must all be equal
    assign upper         = ctrl_i.vaddr[`LSU_XLEN-1:`LSU_VA_BITS-1];
    assign non_canonical = en_ld_st_translation_i && !((&upper) || !(|upper));

    // alignment by access size, bytes never fault
    always_comb begin
        unique case (ctrl_i.op)
            OP_LD, OP_SD:              misaligned = (ctrl_i.vaddr[2:0] != 3'b000);
            OP_LW, OP_LWU, OP_SW:      misaligned = (ctrl_i.vaddr[1:0] != 2'b00);
            OP_LH, OP_LHU, OP_SH:      misaligned = ctrl_i.vaddr[0];
            default:                   misaligned = 1'b0;
        endcase
    end

    always_comb begin
        ex_o      = '0;
        ex_o.tval = ctrl_i.vaddr;
        if (ctrl_i.valid) begin
            // access fault takes priority
            if (non_canonical) begin
                ex_o.valid = (ctrl_i.fu != FU_NONE);
                ex_o.cause = (ctrl_i.fu == FU_STORE) ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
            end else if (misaligned) begin
                ex_o.valid = (ctrl_i.fu != FU_NONE);
                ex_o.cause = (ctrl_i.fu == FU_STORE) ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
            end
        end
    end

endmodule

/* logic/lsu_addr_gen.sv */
// address generation unit, forms the vaddr and byte enable and packs the incoming request
`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_addr_gen import lsu_pkg::*; (
    input  logic [`LSU_XLEN-1:0]          operand_a_i,
    input  logic [`LSU_XLEN-1:0]          imm_i,
    input  logic [`LSU_XLEN-1:0]          operand_b_i,
    input  fu_t                           fu_i,
    input  lsu_op_t                       op_i,
    input  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i,
    input  logic                          lsu_valid_i,
    output lsu_ctrl_t                     req_o
);

    logic [`LSU_XLEN-1:0] vaddr;
    logic [7:0]           be_base;

    // base plus signed immediate, used directly as physical address
    assign vaddr = $unsigned($signed(operand_a_i) + $signed(imm_i));

    // access size as a mask of low bytes
    always_comb begin
        unique case (op_i)
            OP_LB, OP_LBU, OP_SB:  be_base = 8'h01;
            OP_LH, OP_LHU, OP_SH:  be_base = 8'h03;
            OP_LW, OP_LWU, OP_SW:  be_base = 8'h0f;
            default:               be_base = 8'hff;
        endcase
    end

    always_comb begin
        req_o          = '0;
        req_o.valid    = lsu_valid_i;
        req_o.vaddr    = vaddr;
        req_o.data     = operand_b_i;
        // mask moved to the byte offset, overflow of misaligned accesses drops out
        req_o.be       = be_base << vaddr[2:0];
        req_o.fu       = fu_i;
        req_o.op       = op_i;
        req_o.trans_id = trans_id_i;
    end

endmodule

/* logic/lsu_bypass.sv */
// two-entry request buffer between address generation and the units, bypassed when empty
`timescale 1ns/10ps

module lsu_bypass import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  lsu_ctrl_t req_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output lsu_ctrl_t ctrl_o,
    output logic      ready_o
);

    lsu_ctrl_t [1:0] mem_d, mem_q;
    logic [1:0]      valid_d, valid_q;
    logic            wr_d, wr_q;
    logic            rd_d, rd_q;
    logic [1:0]      cnt_d, cnt_q;
    logic            push;
    logic            pop;
    logic            empty;

    assign push    = req_i.valid;
    assign pop     = pop_ld_i | pop_st_i;
    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        mem_d   = mem_q;
        valid_d = valid_q;
        wr_d    = wr_q;
        rd_d    = rd_q;
        cnt_d   = cnt_q;
        if (push) begin
            mem_d[wr_q]   = req_i;
            valid_d[wr_q] = 1'b1;
            wr_d          = wr_q + 1'b1;
        end
        // push and pop on an empty buffer hit the same slot, which ends up invalid
        if (pop) begin
            valid_d[rd_q] = 1'b0;
            rd_d          = rd_q + 1'b1;
        end
        unique case ({push, pop})
            2'b10:   cnt_d = cnt_q + 2'd1;
            2'b01:   cnt_d = cnt_q - 2'd1;
            default: cnt_d = cnt_q;
        endcase
        // flush drops everything held
        if (flush_i) begin
            valid_d = '0;
            wr_d    = 1'b0;
            rd_d    = 1'b0;
            cnt_d   = '0;
        end
    end

    // head is the new request in the same cycle when nothing is held
    always_comb begin
        ctrl_o       = mem_q[rd_q];
        ctrl_o.valid = valid_q[rd_q];
        if (empty) begin
            ctrl_o = req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            wr_q    <= 1'b0;
            rd_q    <= 1'b0;
            cnt_q   <= '0;
        end else begin
            valid_q <= valid_d;
            wr_q    <= wr_d;
            rd_q    <= rd_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_q <= mem_d;
    end

    // issuer honours lsu_ready_o
    a_push_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push |-> empty);
    // no overflow past two entries
    a_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cnt_q == 2'd2) |-> !push);
    // dispatch routes the head to one unit only
    a_one_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_ld_i && pop_st_i));

endmodule

/* logic/lsu_pkg.sv */
// shared types of the load/store front end, imported by every RTL module that needs them
`include "lsu_consts.svh"

package lsu_pkg;

    // functional unit tag
    typedef enum logic [1:0] {
        FU_NONE,
        FU_LOAD,
        FU_STORE
    } fu_t;

    // memory opcodes, loads first
    typedef enum logic [3:0] {
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD,
        OP_SB, OP_SH, OP_SW, OP_SD
    } lsu_op_t;

    // riscv mcause encodings, zero when nothing is raised
    typedef enum logic [3:0] {
        EXC_NONE           = 4'd0,
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } exc_cause_t;

    typedef struct packed {
        exc_cause_t                cause;
        logic [`LSU_XLEN-1:0]      tval;
        logic                      valid;
    } exception_t;

    // one request as it sits in the bypass buffer
    typedef struct packed {
        logic                          valid;
        logic [`LSU_XLEN-1:0]          vaddr;
        logic [`LSU_XLEN-1:0]          data;
        logic [7:0]                    be;
        fu_t                           fu;
        lsu_op_t                       op;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef enum logic {
        LD_IDLE,
        LD_WAIT_RVALID
    } load_state_t;

endpackage

/* logic/lsu_result_pipe.sv */
// register chain that delays one result bundle by a configurable number of cycles
`timescale 1ns/10ps

module lsu_result_pipe #(
    parameter int unsigned width = 1,
    parameter int unsigned depth = 1
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [width-1:0] d_i,
    output logic [width-1:0] d_o
);

    if (depth == 0) begin : g_wire
        assign d_o = d_i;
    end else begin : g_regs
        logic [depth-1:0][width-1:0] q;

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                q <= '0;
            end else begin
                q[0] <= d_i;
                for (int unsigned i = 1; i < depth; i++) begin
                    q[i] <= q[i-1];
                end
            end
        end

        assign d_o = q[depth-1];
    end

endmodule

/* logic/store_unit.sv */
// store unit, issues lane-aligned stores until granted and reports their completion
`timescale 1ns/10ps
`include "lsu_consts.svh"

module store_unit import lsu_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          valid_i,
    input  lsu_ctrl_t                     ctrl_i,
    input  exception_t                    ex_i,
    input  logic                          st_gnt_i,
    output logic                          pop_st_o,
    output logic                          st_req_o,
    output logic [`LSU_XLEN-1:0]          st_addr_o,
    output logic [7:0]                    st_be_o,
    output logic [`LSU_XLEN-1:0]          st_wdata_o,
    output logic                          valid_o,
    output logic [`LSU_TRANS_ID_BITS-1:0] trans_id_o,
    output logic [`LSU_XLEN-1:0]          result_o,
    output exception_t                    ex_o
);

    // request stays up from the buffer head until granted
    assign st_req_o   = valid_i && !ex_i.valid;
    assign st_addr_o  = {ctrl_i.vaddr[`LSU_XLEN-1:3], 3'b000};
    assign st_be_o    = ctrl_i.be;
    // data into the byte lane of its offset
    assign st_wdata_o = ctrl_i.data << {ctrl_i.vaddr[2:0], 3'b000};
    // pop on grant, or at once on a fault
    assign pop_st_o   = valid_i && (ex_i.valid || st_gnt_i);
    // stores write nothing back
    assign result_o   = '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= pop_st_o;
        end
    end

    always_ff @(posedge clk_i) begin
        trans_id_o <= ctrl_i.trans_id;
        ex_o       <= ex_i.valid ? ex_i : '0;
    end

    // buffer head holds still under missing grant
    a_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (st_req_o && !st_gnt_i) ##1 st_req_o |-> $stable({st_addr_o, st_be_o, st_wdata_o}));

endmodule

/* sim.f */
+incdir+include
logic/lsu_pkg.sv
logic/lsu_addr_gen.sv
logic/lsu_bypass.sv
logic/lsu_addr_check.sv
logic/load_unit.sv
logic/store_unit.sv
logic/lsu_result_pipe.sv
logic/load_store_unit.sv
dv/tb_clk_gen.sv
dv/tb_load_store_unit.sv
